//--- build.f
+incdir+tests
hw/mipsPkg.sv
hw/opcodeDecoder.sv
hw/functDecoder.sv
hw/controlDecoder.sv
hw/alu.sv
hw/registerFile.sv
hw/instrMemory.sv
hw/dataMemory.sv
hw/mipsCore.sv
tests/mipsCoreTb.sv

//--- tests/programTable.svh
/* Program image and expected retirement trace for the core testbench.
   Included inside the testbench module, after the package import. */

localparam int programLen = 24;
localparam int traceLen   = 13;

typedef struct packed {
    logic [127:0] name;
    logic         isMem;
    regWriteT     regEvt;
    memWriteT     memEvt;
} traceEntryT;

function automatic logic [31:0] programWord(input int idx);
    case (idx)
        0:  programWord = 32'h3801_0005;  // xori r1, r0, 0x0005
        1:  programWord = 32'h3802_8003;  // xori r2, r0, 0x8003
        2:  programWord = 32'h0022_1820;  // add  r3, r1, r2
        3:  programWord = 32'h0022_2022;  // sub  r4, r1, r2
        4:  programWord = 32'h0081_282A;  // slt  r5, r4, r1
        5:  programWord = 32'h0024_302A;  // slt  r6, r1, r4
        6:  programWord = 32'hAC23_0003;  // sw   r3, 3(r1)
        7:  programWord = 32'h8C27_0003;  // lw   r7, 3(r1)
        8:  programWord = 32'h1422_0001;  // bne  r1, r2, +1 (taken)
        9:  programWord = 32'h3808_00AA;  // xori r8, r0, 0x00AA (skipped)
        10: programWord = 32'h1467_0001;  // bne  r3, r7, +1 (falls through)
        11: programWord = 32'h3809_0011;  // xori r9, r0, 0x0011
        12: programWord = 32'h0C00_0016;  // jal  22
        13: programWord = 32'h380A_0022;  // xori r10, r0, 0x0022
        14: programWord = 32'h0800_0011;  // j    17
        15: programWord = 32'h380B_0033;  // xori r11, r0, 0x0033 (skipped)
        16: programWord = 32'h380C_0044;  // xori r12, r0, 0x0044 (skipped)
        17: programWord = 32'h3820_00FF;  // xori r0, r1, 0x00FF (dropped)
        18: programWord = 32'hFC2F_7800;  // unknown opcode, rs r1, rt and rd r15
        19: programWord = 32'h0002_6820;  // add  r13, r0, r2
        20: programWord = 32'h0800_0014;  // j    20, parking loop
        22: programWord = 32'h382E_000F;  // xori r14, r1, 0x000F
        23: programWord = 32'h03E0_0008;  // jr   r31
        default: programWord = 32'h0000_0000;
    endcase
endfunction

function automatic traceEntryT makeEntry(input logic [127:0] name, input logic isMem,
                                         input logic [31:0] addr, input logic [31:0] data);
    traceEntryT e;
    e.name   = name;
    e.isMem  = isMem;
    e.regEvt = {!isMem, addr[4:0], data};
    e.memEvt = {isMem, addr, data};
    return e;
endfunction

// Retirement order, skipped and dropped writes are absent
function automatic traceEntryT expectedTrace(input int idx);
    case (idx)
        0:  expectedTrace = makeEntry("xori r1", 1'b0, 32'd1, 32'h0000_0005);
        1:  expectedTrace = makeEntry("xori r2 zext", 1'b0, 32'd2, 32'h0000_8003);
        2:  expectedTrace = makeEntry("add r3", 1'b0, 32'd3, 32'h0000_8008);
        3:  expectedTrace = makeEntry("sub r4", 1'b0, 32'd4, 32'hFFFF_8002);
        4:  expectedTrace = makeEntry("slt r5 negative", 1'b0, 32'd5, 32'h0000_0001);
        5:  expectedTrace = makeEntry("slt r6", 1'b0, 32'd6, 32'h0000_0000);
        6:  expectedTrace = makeEntry("sw r3", 1'b1, 32'h0000_0008, 32'h0000_8008);
        7:  expectedTrace = makeEntry("lw r7", 1'b0, 32'd7, 32'h0000_8008);
        8:  expectedTrace = makeEntry("xori r9", 1'b0, 32'd9, 32'h0000_0011);
        9:  expectedTrace = makeEntry("jal link", 1'b0, 32'd31, 32'h0000_0034);
        10: expectedTrace = makeEntry("xori r14", 1'b0, 32'd14, 32'h0000_000A);
        11: expectedTrace = makeEntry("xori r10 return", 1'b0, 32'd10, 32'h0000_0022);
        12: expectedTrace = makeEntry("add r13 from r0", 1'b0, 32'd13, 32'h0000_8003);
        default: expectedTrace = '0;
    endcase
endfunction

//--- tests/mipsCoreTb.sv
/* Self-checking testbench for mipsCore. Loads the program during reset and
   compares every register write and store against the expected trace. */
`timescale 1ns/1ns

module mipsCoreTb import mipsPkg::*; ();

    localparam int resetCycles = 5;
    localparam int drainCycles = 8;

    `include "programTable.svh"

    // Load time is part of the reset period
    localparam int cycleLimit = 4 * traceLen + programLen + resetCycles;

    logic        clk;
    logic        reset;
    logic        loadEn;
    logic [31:0] loadAddr;
    logic [31:0] loadData;
    logic [31:0] pc;
    regWriteT    regTrace;
    memWriteT    memTrace;

    int cycleCount;
    int traceIndex;
    int checkCount;
    int errorCount;

    mipsCore #(
        .instrDepth (64),
        .dataDepth  (64)
    ) u_dut (
        .clk      (clk),
        .reset    (reset),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .pc       (pc),
        .regTrace (regTrace),
        .memTrace (memTrace)
    );

    always #4 clk = ~clk;

    task automatic checkRegWrite(input logic [127:0] name, input regWriteT expected,
                                 input regWriteT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %0s: expected r%0d = %h, actual r%0d = %h", name,
                     expected.addr, expected.data, actual.addr, actual.data);
        end
    endtask

    task automatic checkMemWrite(input logic [127:0] name, input memWriteT expected,
                                 input memWriteT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %0s: expected mem[%h] = %h, actual mem[%h] = %h", name,
                     expected.addr, expected.data, actual.addr, actual.data);
        end
    endtask

    task automatic checkPc(input logic [127:0] name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %0s: expected pc %h, actual pc %h", name, expected, actual);
        end
    endtask

    // Pairs one trace event with the next table entry
    task automatic matchEvent(input logic isMem, input regWriteT actReg,
                              input memWriteT actMem);
        traceEntryT exp;
        if (traceIndex >= traceLen) begin
            errorCount++;
            $display("A trace event arrived after the expected trace was complete");
        end else begin
            exp = expectedTrace(traceIndex);
            traceIndex++;
            if (exp.isMem != isMem) begin
                errorCount++;
                $display("%0s: the core produced the other kind of write", exp.name);
            end else if (isMem) begin
                checkMemWrite(exp.name, exp.memEvt, actMem);
            end else begin
                checkRegWrite(exp.name, exp.regEvt, actReg);
            end
        end
    endtask

    task automatic finishRun();
        $display("Checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            if (cycleCount > 0) begin
                checkPc("pc in reset", 32'd0, pc);
                if (regTrace.valid !== 1'b0 || memTrace.valid !== 1'b0) begin
                    errorCount++;
                    $display("A trace valid was high while reset was asserted");
                end
            end
        end else begin
            if (regTrace.valid !== 1'b0) begin
                matchEvent(1'b0, regTrace, memTrace);
            end
            if (memTrace.valid !== 1'b0) begin
                matchEvent(1'b1, regTrace, memTrace);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            errorCount++;
            $display("Timeout after %0d cycles, only %0d of %0d trace events seen",
                     cycleCount, traceIndex, traceLen);
            finishRun();
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        cycleCount = 0;
        traceIndex = 0;
        checkCount = 0;
        errorCount = 0;

        // Program load while the core is held in reset
        for (int i = 0; i < programLen; i++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= i;
            loadData <= programWord(i);
        end
        @(posedge clk);
        loadEn <= 1'b0;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;

        wait (traceIndex == traceLen);
        // A few idle cycles catch any stray write after the last entry
        repeat (drainCycles) @(posedge clk);
        finishRun();
    end

endmodule

//--- hw/mipsCore.sv
/* Single-cycle core for the MIPS subset, one instruction retired per clock.
   The write bundles leave the core as trace outputs for checking. */
`timescale 1ns/1ns

module mipsCore import mipsPkg::*; #(
    parameter int instrDepth = 64,
    parameter int dataDepth  = 64
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        loadEn,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData,
    output logic [31:0] pc,
    output regWriteT    regTrace,
    output memWriteT    memTrace
);

    logic [31:0] instr;
    ctrlT        ctrl;

    // Instruction fields
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm16;
    logic [25:0] target26;

    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] signImm;
    logic [31:0] immExt;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic        aluZero;
    logic [31:0] memReadData;

    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;
    logic [4:0]  destReg;
    logic [31:0] wbData;

    instrMemory #(
        .instrDepth (instrDepth)
    ) u_instrMemory (
        .clk      (clk),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .pc       (pc),
        .instr    (instr)
    );

    controlDecoder u_controlDecoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign imm16    = instr[15:0];
    assign target26 = instr[25:0];

    registerFile u_registerFile (
        .clk    (clk),
        .reset  (reset),
        .rsAddr (rs),
        .rtAddr (rt),
        .rsData (rsData),
        .rtData (rtData),
        .write  (regTrace)
    );

    assign signImm = {{16{imm16[15]}}, imm16};
    assign immExt  = ctrl.signExt ? signImm : {16'd0, imm16};
    assign aluB    = ctrl.aluSrcReg ? rtData : immExt;

    alu u_alu (
        .a      (rsData),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    dataMemory #(
        .dataDepth (dataDepth)
    ) u_dataMemory (
        .clk      (clk),
        .reset    (reset),
        .readAddr (aluResult),
        .readData (memReadData),
        .write    (memTrace)
    );

    // Destination and write-back selection
    always_comb begin
        case (ctrl.regDst)
            dstRd:   destReg = rd;
            dstRa:   destReg = 5'd31;
            default: destReg = rt;
        endcase
        case (ctrl.wbSrc)
            wbMem:   wbData = memReadData;
            wbLink:  wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

    // Writes to register 0 never reach the trace
    assign regTrace.valid = ctrl.regWrite && (destReg != 5'd0) && !reset;
    assign regTrace.addr  = destReg;
    assign regTrace.data  = wbData;

    assign memTrace.valid = ctrl.memWrite && !reset;
    assign memTrace.addr  = aluResult;
    assign memTrace.data  = rtData;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], target26, 2'b00};

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = rsData;
        end else if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (ctrl.branch && !aluZero) begin
            // BNE taken when operands differ
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

//--- hw/dataMemory.sv
/* Word-addressed data store for LW and SW, with a combinational read
   and a write on the clock edge. */
`timescale 1ns/1ns

module dataMemory import mipsPkg::*; #(
    parameter int dataDepth = 64
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] readAddr,
    output logic [31:0] readData,
    input  memWriteT    write
);

    localparam int addrW = $clog2(dataDepth);

    logic [31:0] mem [dataDepth];
    logic [29:0] readIndex;
    logic [29:0] writeIndex;

    assign readIndex  = readAddr[31:2];
    assign writeIndex = write.addr[31:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dataDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (write.valid && writeIndex < dataDepth) begin
            mem[writeIndex[addrW-1:0]] <= write.data;
        end
    end

    assign readData = (readIndex < dataDepth) ? mem[readIndex[addrW-1:0]] : 32'd0;

endmodule

//--- hw/instrMemory.sv
/* Instruction store, filled through the load port during reset and read
   combinationally at the program counter. */
`timescale 1ns/1ns

module instrMemory #(
    parameter int instrDepth = 64
) (
    input  logic        clk,
    input  logic        loadEn,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData,
    input  logic [31:0] pc,
    output logic [31:0] instr
);

    localparam int addrW = $clog2(instrDepth);

    logic [31:0] mem [instrDepth];
    logic [29:0] fetchIndex;

    always_ff @(posedge clk) begin
        if (loadEn && loadAddr < instrDepth) begin
            mem[loadAddr[addrW-1:0]] <= loadData;
        end
    end

    assign fetchIndex = pc[31:2];

    // Outside the program a zero word is returned, which is a no-op
    assign instr = (fetchIndex < instrDepth) ? mem[fetchIndex[addrW-1:0]] : 32'd0;

endmodule

//--- hw/registerFile.sv
/* General-purpose register file, 32 words, two read ports and one write port.
   Register 0 always reads as zero. */
`timescale 1ns/1ns

module registerFile import mipsPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    input  regWriteT    write
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write.valid && write.addr != 5'd0) begin
            regs[write.addr] <= write.data;
        end
    end

    // Asynchronous reads
    always_comb begin
        if (rsAddr == 5'd0) begin
            rsData = '0;
        end else begin
            rsData = regs[rsAddr];
        end
        if (rtAddr == 5'd0) begin
            rtData = '0;
        end else begin
            rtData = regs[rtAddr];
        end
    end

endmodule

//--- hw/alu.sv
/* 32-bit ALU with eight operations and a zero flag for branch compares. */
`timescale 1ns/1ns

module alu import mipsPkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  aluOpT       op,
    output logic [31:0] result,
    output logic        zero
);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluXor:  result = a ^ b;
            aluAnd:  result = a & b;
            aluNand: result = ~(a & b);
            aluNor:  result = ~(a | b);
            aluOr:   result = a | b;
            aluSlt: begin
                // Signed compare
                if ($signed(a) < $signed(b)) begin
                    result = 32'd1;
                end else begin
                    result = 32'd0;
                end
            end
            default: result = a + b;
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

//--- hw/controlDecoder.sv
/* Instruction decoder that picks the funct table for R-type words and
   the opcode table for everything else. */
`timescale 1ns/1ns

module controlDecoder import mipsPkg::*; (
    input  logic [31:0] instr,
    output ctrlT        ctrl
);

    opcodeT opcode;
    functT  funct;
    ctrlT   opcodeCtrl;
    ctrlT   functCtrl;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    opcodeDecoder u_opcodeDecoder (
        .opcode (opcode),
        .ctrl   (opcodeCtrl)
    );

    functDecoder u_functDecoder (
        .funct (funct),
        .ctrl  (functCtrl)
    );

    assign ctrl = (opcode == opR) ? functCtrl : opcodeCtrl;

endmodule

//--- hw/functDecoder.sv
/* Control table for R-type instructions, indexed by the funct field. */
`timescale 1ns/1ns

module functDecoder import mipsPkg::*; (
    input  functT funct,
    output ctrlT  ctrl
);

    always_comb begin
        ctrl = '0;
        case (funct)
            functJr: begin
                // Register jump, nothing is written
                ctrl.jumpReg = 1'b1;
            end
            functAdd, functSub, functSlt: begin
                ctrl.regWrite  = 1'b1;
                ctrl.regDst    = dstRd;
                ctrl.aluSrcReg = 1'b1;
                ctrl.wbSrc     = wbAlu;
                case (funct)
                    functSub: ctrl.aluOp = aluSub;
                    functSlt: ctrl.aluOp = aluSlt;
                    default:  ctrl.aluOp = aluAdd;
                endcase
            end
            default: ctrl = '0;
        endcase
    end

endmodule

//--- hw/opcodeDecoder.sv
/* Control table for the I-type and J-type opcodes of the subset.
   R-type instructions are handled by the funct table instead. */
`timescale 1ns/1ns

module opcodeDecoder import mipsPkg::*; (
    input  opcodeT opcode,
    output ctrlT   ctrl
);

    always_comb begin
        // Unknown opcodes fall out as a no-op
        ctrl = '0;
        case (opcode)
            opBne: begin
                ctrl.aluSrcReg = 1'b1;
                ctrl.aluOp     = aluSub;
                ctrl.branch    = 1'b1;
                ctrl.signExt   = 1'b1;
            end
            opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRt;
                ctrl.aluOp    = aluAdd;
                ctrl.wbSrc    = wbMem;
                ctrl.signExt  = 1'b1;
            end
            opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
                ctrl.signExt  = 1'b1;
            end
            opJ: begin
                ctrl.jump = 1'b1;
            end
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRa;
                ctrl.wbSrc    = wbLink;
                ctrl.jump     = 1'b1;
            end
            opXori: begin
                // Zero-extended immediate, so signExt stays clear
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRt;
                ctrl.aluOp    = aluXor;
                ctrl.wbSrc    = wbAlu;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

//--- hw/mipsPkg.sv
/* Shared encodings and bundles for the single-cycle MIPS subset core.
   Imported by the decoders, the datapath blocks and the testbench. */
package mipsPkg;

    // Primary opcode field, instr[31:26]
    typedef logic [5:0] opcodeT;

    localparam opcodeT opR    = 6'd0;
    localparam opcodeT opJ    = 6'd2;
    localparam opcodeT opJal  = 6'd3;
    localparam opcodeT opBne  = 6'd5;
    localparam opcodeT opXori = 6'd14;
    localparam opcodeT opLw   = 6'd35;
    localparam opcodeT opSw   = 6'd43;

    // R-type function field, instr[5:0]
    typedef logic [5:0] functT;

    localparam functT functJr  = 6'd8;
    localparam functT functAdd = 6'd32;
    localparam functT functSub = 6'd34;
    localparam functT functSlt = 6'd42;

    typedef enum logic [2:0] {
        aluAdd  = 3'd0,
        aluSub  = 3'd1,
        aluXor  = 3'd2,
        aluSlt  = 3'd3,
        aluAnd  = 3'd4,
        aluNand = 3'd5,
        aluNor  = 3'd6,
        aluOr   = 3'd7
    } aluOpT;

    // Destination register choice, dstRa is the link register 31
    typedef enum logic [1:0] {
        dstRt = 2'd0,
        dstRd = 2'd1,
        dstRa = 2'd2
    } regDstT;

    // Write-back source, wbLink writes PC plus 4
    typedef enum logic [1:0] {
        wbMem  = 2'd0,
        wbAlu  = 2'd1,
        wbLink = 2'd2
    } wbSrcT;

    typedef struct packed {
        logic   regWrite;
        logic   memWrite;
        regDstT regDst;
        logic   aluSrcReg;
        aluOpT  aluOp;
        wbSrcT  wbSrc;
        logic   jumpReg;
        logic   jump;
        logic   branch;
        logic   signExt;
    } ctrlT;

    typedef struct packed {
        logic        valid;
        logic [4:0]  addr;
        logic [31:0] data;
    } regWriteT;

    // Store bundle, addr is a byte address
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } memWriteT;

endpackage
